// ==== verilog/mem_stage_pkg.sv ====
package mem_stage_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and address width
  localparam int xlen = 32;

  // Register index width
  localparam int reg_aw = 5;

  // Byte lanes per word and lane width
  localparam int num_lanes = 4;
  localparam int lane_w    = 8;

  // Word address width of the data RAM
  // Address bits 11:2 pick the word and bits 1:0 the byte
  localparam int ram_aw    = 10;
  localparam int ram_depth = 1 << ram_aw;

  ////////////////////////////////////////
  // Operation kinds
  ////////////////////////////////////////

  // Store size
  typedef enum logic [1:0] {
    st_none = 2'd0,
    st_b    = 2'd1,
    st_h    = 2'd2,
    st_w    = 2'd3
  } store_op_e;

  // Load format with signed and unsigned kinds
  typedef enum logic [2:0] {
    ld_none = 3'd0,
    ld_b    = 3'd1,
    ld_h    = 3'd2,
    ld_w    = 3'd3,
    ld_bu   = 3'd4,
    ld_hu   = 3'd5
  } load_op_e;

endpackage : mem_stage_pkg

// ==== verilog/mem_stage_if.sv ====
////////////////////////////////////////
// EX/MEM pipeline values
////////////////////////////////////////

interface ex_mem_if import mem_stage_pkg::*; ();

  // ALU result that is also the memory address
  logic [xlen-1:0]   alures;
  // Store source register and its value
  logic [xlen-1:0]   rs2_data;
  logic [reg_aw-1:0] rs2;
  // Destination register
  logic [reg_aw-1:0] rd;
  logic              regwrite;
  logic              memread;
  logic              memwrite;
  store_op_e         store_op;
  load_op_e          load_op;

  // Store path toward the RAM
  modport store_side (
    input alures, rs2_data, rs2, memread, memwrite, store_op
  );

  // MEM/WB capture
  modport capture_side (
    input alures, rd, regwrite, memread, load_op
  );

  // Driver at the top level
  modport source (
    output alures, rs2_data, rs2, rd, regwrite, memread, memwrite, store_op, load_op
  );

endinterface : ex_mem_if

////////////////////////////////////////
// Data RAM port
////////////////////////////////////////

interface ram_port_if import mem_stage_pkg::*; ();

  logic                 wea;
  // One enable per byte lane
  logic [num_lanes-1:0] en;
  logic [ram_aw-1:0]    addr;
  logic [xlen-1:0]      din;
  // Registered read word
  logic [xlen-1:0]      dout;

  modport requester (output wea, en, addr, din);
  modport memory    (input wea, en, addr, din, output dout);
  modport reader    (input dout);

endinterface : ram_port_if

// ==== verilog/store_lane_unit.sv ====
module store_lane_unit import mem_stage_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall,
  ex_mem_if.store_side      ex,
  input  logic [xlen-1:0]   wb_res,
  input  logic [reg_aw-1:0] wb_rd,
  input  logic              wb_regwrite,
  ram_port_if.requester     ram
);

  logic                   fwd;
  logic [xlen-1:0]        src;
  logic [1:0]             offset;
  logic [2*xlen-1:0]      src_dbl;
  logic [2*num_lanes-1:0] half_dbl;

  // Byte position inside the word
  assign offset = ex.alures[1:0];

  ////////////////////////////////////////
  // Store forwarding
  ////////////////////////////////////////

  // Instruction ahead writes the register this store reads
  // e.g. lw x5 followed by sw x5
  assign fwd = ex.memwrite && wb_regwrite && (wb_rd == ex.rs2);

  // Take the writeback result over the stale register value
  assign src = fwd ? wb_res : ex.rs2_data;

  ////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////

  // Halfword pair shifted by the offset; upper half folds back to lane 0
  assign half_dbl = {{num_lanes{1'b0}}, 4'b0011} << offset;

  always_comb begin
    unique case (ex.store_op)
      // One addressed lane
      st_b:    ram.en = 4'b0001 << offset;
      // Two lanes, wrapping, so offset 3 gives lanes 3 and 0
      st_h:    ram.en = half_dbl[num_lanes-1:0] | half_dbl[2*num_lanes-1:num_lanes];
      // Word store or no store at all
      default: ram.en = '1;
    endcase
  end

  ////////////////////////////////////////
  // Lane rotation and RAM request
  ////////////////////////////////////////

  // Rotate left by offset bytes so byte 0 lands in the addressed lane
  assign src_dbl = {src, src} << {offset, 3'b000};
  assign ram.din = src_dbl[2*xlen-1:xlen];

  // Word address
  assign ram.addr = ex.alures[ram_aw+1:2];

  // No write while the stage is frozen
  assign ram.wea = ex.memwrite && !stall;

  // Decoder never flags a load and a store together
  a_no_rd_wr : assert property (
    @(posedge clk) disable iff (!rst_n)
    ex.memwrite |-> !ex.memread
  );

  // A memory write always carries a size
  a_store_sized : assert property (
    @(posedge clk) disable iff (!rst_n)
    ex.memwrite |-> (ex.store_op != st_none)
  );

endmodule : store_lane_unit

// ==== verilog/data_ram.sv ====
module data_ram import mem_stage_pkg::*; (
  input  logic       clk,
  input  logic       stall,
  ram_port_if.memory ram
);

  ////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////

  // One byte-wide block RAM per lane
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane

    logic [lane_w-1:0] mem [ram_depth];
    logic [lane_w-1:0] dout_q;

    // Write only when this lane is enabled
    always_ff @(posedge clk) begin
      if (ram.wea && ram.en[i]) begin
        mem[ram.addr] <= ram.din[i*lane_w +: lane_w];
      end
    end

    // Read register holds under stall
    // Old contents come out on a same-address write (read-first)
    always_ff @(posedge clk) begin
      if (!stall) begin
        dout_q <= mem[ram.addr];
      end
    end

    assign ram.dout[i*lane_w +: lane_w] = dout_q;

  end : g_lane

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A write strobe with no lane enabled would be lost silently
  a_wr_has_lane : assert property (
    @(posedge clk)
    ram.wea |-> (ram.en != '0)
  );

endmodule : data_ram

// ==== verilog/mem_wb_reg.sv ====
module mem_wb_reg import mem_stage_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall,
  ex_mem_if.capture_side    ex,
  output logic [xlen-1:0]   wb_alures,
  output logic              wb_memread,
  output load_op_e          wb_load_op,
  output logic [1:0]        wb_offset,
  output logic [reg_aw-1:0] wb_rd,
  output logic              wb_regwrite
);

  ////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // Empty stage after reset
      wb_alures   <= '0;
      wb_memread  <= 1'b0;
      wb_load_op  <= ld_none;
      wb_offset   <= 2'b00;
      wb_rd       <= '0;
      wb_regwrite <= 1'b0;
    end else if (!stall) begin
      // Advance one instruction per unstalled edge
      wb_alures   <= ex.alures;
      wb_memread  <= ex.memread;
      wb_load_op  <= ex.load_op;
      // Byte offset picks the lane on the read side
      wb_offset   <= ex.alures[1:0];
      wb_rd       <= ex.rd;
      wb_regwrite <= ex.regwrite;
    end
  end

  // Every load names its format
  a_load_formatted : assert property (
    @(posedge clk) disable iff (!rst_n)
    ex.memread |-> (ex.load_op != ld_none)
  );

endmodule : mem_wb_reg

// ==== verilog/writeback_select.sv ====
module writeback_select import mem_stage_pkg::*; (
  ram_port_if.reader       ram,
  input  logic [xlen-1:0]  wb_alures,
  input  logic             wb_memread,
  input  load_op_e         wb_load_op,
  input  logic [1:0]       wb_offset,
  output logic [xlen-1:0]  wb_res
);

  logic [2*xlen-1:0] word_dbl;
  logic [xlen-1:0]   word_rot;
  logic [xlen-1:0]   load_val;

  ////////////////////////////////////////
  // Lane alignment
  ////////////////////////////////////////

  // Rotate right by offset bytes
  // Addressed byte ends up in bits 7:0
  assign word_dbl = {ram.dout, ram.dout} >> {wb_offset, 3'b000};
  assign word_rot = word_dbl[xlen-1:0];

  ////////////////////////////////////////
  // Load format
  ////////////////////////////////////////

  always_comb begin
    unique case (wb_load_op)
      // Signed byte
      ld_b:    load_val = {{(xlen-8){word_rot[7]}}, word_rot[7:0]};
      // Signed halfword
      ld_h:    load_val = {{(xlen-16){word_rot[15]}}, word_rot[15:0]};
      // Whole word passed through
      ld_w:    load_val = word_rot;
      // Unsigned byte
      ld_bu:   load_val = {{(xlen-8){1'b0}}, word_rot[7:0]};
      // Unsigned halfword
      ld_hu:   load_val = {{(xlen-16){1'b0}}, word_rot[15:0]};
      // No load
      default: load_val = '0;
    endcase
  end

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  // Loads take the memory value, everything else the ALU result
  assign wb_res = wb_memread ? load_val : wb_alures;

endmodule : writeback_select

// ==== verilog/mem_stage_top.sv ====
module mem_stage_top import mem_stage_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall,
  input  logic [xlen-1:0]   ex_alures,
  input  logic [xlen-1:0]   ex_rs2_data,
  input  logic [reg_aw-1:0] ex_rs2,
  input  logic [reg_aw-1:0] ex_rd,
  input  logic              ex_regwrite,
  input  logic              ex_memread,
  input  logic              ex_memwrite,
  input  store_op_e         ex_store_op,
  input  load_op_e          ex_load_op,
  output logic [xlen-1:0]   wb_res,
  output logic [reg_aw-1:0] wb_rd,
  output logic              wb_regwrite
);

  // MEM/WB values toward the writeback select
  logic [xlen-1:0] wb_alures;
  logic            wb_memread;
  load_op_e        wb_load_op;
  logic [1:0]      wb_offset;

  ex_mem_if   ex_mem ();
  ram_port_if ram_port ();

  ////////////////////////////////////////
  // EX/MEM inputs onto the bundle
  ////////////////////////////////////////

  assign ex_mem.alures   = ex_alures;
  assign ex_mem.rs2_data = ex_rs2_data;
  assign ex_mem.rs2      = ex_rs2;
  assign ex_mem.rd       = ex_rd;
  assign ex_mem.regwrite = ex_regwrite;
  assign ex_mem.memread  = ex_memread;
  assign ex_mem.memwrite = ex_memwrite;
  assign ex_mem.store_op = ex_store_op;
  assign ex_mem.load_op  = ex_load_op;

  ////////////////////////////////////////
  // Stage blocks
  ////////////////////////////////////////

  // Store path with forwarding from the writeback result
  store_lane_unit i_store_lane_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .ex          (ex_mem.store_side),
    .wb_res      (wb_res),
    .wb_rd       (wb_rd),
    .wb_regwrite (wb_regwrite),
    .ram         (ram_port.requester)
  );

  data_ram i_data_ram (
    .clk   (clk),
    .stall (stall),
    .ram   (ram_port.memory)
  );

  mem_wb_reg i_mem_wb_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .ex          (ex_mem.capture_side),
    .wb_alures   (wb_alures),
    .wb_memread  (wb_memread),
    .wb_load_op  (wb_load_op),
    .wb_offset   (wb_offset),
    .wb_rd       (wb_rd),
    .wb_regwrite (wb_regwrite)
  );

  writeback_select i_writeback_select (
    .ram        (ram_port.reader),
    .wb_alures  (wb_alures),
    .wb_memread (wb_memread),
    .wb_load_op (wb_load_op),
    .wb_offset  (wb_offset),
    .wb_res     (wb_res)
  );

endmodule : mem_stage_top

// ==== verif/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock with an 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset low over the first three rising edges
  // Release lands 1 ns after an edge like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule : tb_clock_gen

// ==== verif/tb_checker.sv ====
module tb_checker import mem_stage_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stall,
  input  logic [xlen-1:0]   ex_alures,
  input  logic [xlen-1:0]   ex_rs2_data,
  input  logic [reg_aw-1:0] ex_rs2,
  input  logic [reg_aw-1:0] ex_rd,
  input  logic              ex_regwrite,
  input  logic              ex_memread,
  input  logic              ex_memwrite,
  input  store_op_e         ex_store_op,
  input  load_op_e          ex_load_op,
  input  logic [xlen-1:0]   wb_res,
  input  logic [reg_aw-1:0] wb_rd,
  input  logic              wb_regwrite,
  input  int                max_cycles,
  output int                checks,
  output int                err_res,
  output int                err_rd,
  output int                err_regwrite,
  output logic              timed_out
);

  timeunit 1ns;
  timeprecision 100ps;

  // Model memory over the 16-word window at address 0
  logic [xlen-1:0]   model_mem [16];
  // Model MEM/WB stage that the outputs must match
  logic [xlen-1:0]   exp_res;
  logic [reg_aw-1:0] exp_rd;
  logic              exp_regwrite;
  logic              primed;
  int                cycles;

  ////////////////////////////////////////
  // Memory rules
  ////////////////////////////////////////

  // Byte b of the aligned value comes from lane off+b with wraparound
  function automatic logic [xlen-1:0] load_value(
    input logic [xlen-1:0] word,
    input logic [1:0]      off,
    input load_op_e        lop
  );
    logic [xlen-1:0] r;
    for (int b = 0; b < num_lanes; b++) begin
      r[8*b +: 8] = word[8*((off + b) % num_lanes) +: 8];
    end
    case (lop)
      ld_b:    return {{24{r[7]}}, r[7:0]};
      ld_h:    return {{16{r[15]}}, r[15:0]};
      ld_w:    return r;
      ld_bu:   return {24'd0, r[7:0]};
      ld_hu:   return {16'd0, r[15:0]};
      default: return '0;
    endcase
  endfunction

  // Source byte k lands in lane off+k for each byte of the size
  function automatic logic [xlen-1:0] store_merge(
    input logic [xlen-1:0] old,
    input logic [xlen-1:0] src,
    input logic [1:0]      off,
    input store_op_e       sop
  );
    logic [xlen-1:0] w;
    int              nbytes;
    int              lane;
    w = old;
    nbytes = (sop == st_b) ? 1 : (sop == st_h) ? 2 : 4;
    for (int k = 0; k < nbytes; k++) begin
      lane = (off + k) % num_lanes;
      w[8*lane +: 8] = src[8*k +: 8];
    end
    return w;
  endfunction

  initial begin
    checks       = 0;
    err_res      = 0;
    err_rd       = 0;
    err_regwrite = 0;
    timed_out    = 1'b0;
    primed       = 1'b0;
    cycles       = 0;
  end

  ////////////////////////////////////////
  // Model step at each rising edge
  ////////////////////////////////////////

  always @(posedge clk) begin : model_step
    logic [xlen-1:0] src;
    logic [xlen-1:0] new_res;
    primed = 1'b1;
    cycles++;
    if (cycles >= max_cycles) begin
      timed_out = 1'b1;
    end
    if (!rst_n) begin
      exp_res      = '0;
      exp_rd       = '0;
      exp_regwrite = 1'b0;
    end else if (!stall) begin
      // Forward from the instruction ahead when it writes rs2
      src = (exp_regwrite && exp_rd == ex_rs2) ? exp_res : ex_rs2_data;
      // Load reads the memory before this edge's write
      new_res = ex_memread ?
                load_value(model_mem[ex_alures[5:2]], ex_alures[1:0], ex_load_op) :
                ex_alures;
      if (ex_memwrite) begin
        model_mem[ex_alures[5:2]] =
          store_merge(model_mem[ex_alures[5:2]], src, ex_alures[1:0], ex_store_op);
      end
      exp_res      = new_res;
      exp_rd       = ex_rd;
      exp_regwrite = ex_regwrite;
    end
    // Stalled edge keeps the model as it is
  end

  ////////////////////////////////////////
  // Compare mid-cycle
  ////////////////////////////////////////

  always @(negedge clk) begin
    if (primed) begin
      checks++;
      if (wb_res !== exp_res) begin
        err_res++;
        $display("FAILED time %0d ns: wb_res %h, expected %h", $time, wb_res, exp_res);
      end
      if (wb_rd !== exp_rd) begin
        err_rd++;
        $display("FAILED time %0d ns: wb_rd %0d, expected %0d", $time, wb_rd, exp_rd);
      end
      if (wb_regwrite !== exp_regwrite) begin
        err_regwrite++;
        $display("FAILED time %0d ns: wb_regwrite %b, expected %b",
                 $time, wb_regwrite, exp_regwrite);
      end
    end
  end

endmodule : tb_checker

// ==== verif/tb_mem_stage.sv ====
module tb_mem_stage import mem_stage_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // Operations per phase
  localparam int n_idle  = 4;
  localparam int n_fill  = 16;
  localparam int n_store = 24;
  localparam int n_load  = 32;
  localparam int n_fwd   = 12;
  localparam int n_stall = 32;
  // Unstalled cycles of the whole run including directed extras and tail
  localparam int run_cycles = n_idle + 2*n_fill + 2*n_store + 3 + n_load
                              + 3*n_fwd + n_stall + 2;
  localparam int timeout_cycles = 4*run_cycles + 100;

  logic              clk;
  logic              rst_n;
  logic              stall;
  logic [xlen-1:0]   ex_alures;
  logic [xlen-1:0]   ex_rs2_data;
  logic [reg_aw-1:0] ex_rs2;
  logic [reg_aw-1:0] ex_rd;
  logic              ex_regwrite;
  logic              ex_memread;
  logic              ex_memwrite;
  store_op_e         ex_store_op;
  load_op_e          ex_load_op;
  logic [xlen-1:0]   wb_res;
  logic [reg_aw-1:0] wb_rd;
  logic              wb_regwrite;
  int                checks;
  int                err_res;
  int                err_rd;
  int                err_regwrite;
  logic              timed_out;
  logic [31:0]       lfsr_state;
  logic              stall_phase;

  tb_clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

  mem_stage_top i_mem_stage_top (.*);

  tb_checker i_checker (.max_cycles(timeout_cycles), .*);

  ////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  ////////////////////////////////////////
  // Operation drivers
  ////////////////////////////////////////

  // Entered 1 ns after an edge and left 1 ns after the accepting edge
  task automatic present(
    input logic [xlen-1:0]   alures,
    input logic [xlen-1:0]   rs2_data,
    input logic [reg_aw-1:0] rs2,
    input logic [reg_aw-1:0] rd,
    input logic              regwrite,
    input logic              memread,
    input logic              memwrite,
    input store_op_e         sop,
    input load_op_e          lop
  );
    logic [31:0] b;
    ex_alures   = alures;
    ex_rs2_data = rs2_data;
    ex_rs2      = rs2;
    ex_rd       = rd;
    ex_regwrite = regwrite;
    ex_memread  = memread;
    ex_memwrite = memwrite;
    ex_store_op = sop;
    ex_load_op  = lop;
    stall = 1'b0;
    if (stall_phase) begin
      take_bits(1, b);
      stall = b[0];
    end
    // Inputs held for as long as stall stays up
    while (stall) begin
      @(posedge clk);
      #1;
      take_bits(1, b);
      stall = b[0];
    end
    @(posedge clk);
    #1;
  endtask

  task automatic bubble();
    present('0, '0, '0, '0, 1'b0, 1'b0, 1'b0, st_none, ld_none);
  endtask

  task automatic alu_op(input logic [31:0] value, input logic [4:0] rd, input logic wr);
    present(value, '0, '0, rd, wr, 1'b0, 1'b0, st_none, ld_none);
  endtask

  task automatic store_at(
    input logic [3:0]  word,
    input logic [1:0]  off,
    input store_op_e   sop,
    input logic [31:0] data,
    input logic [4:0]  rs2
  );
    present({26'd0, word, off}, data, rs2, '0, 1'b0, 1'b0, 1'b1, sop, ld_none);
  endtask

  task automatic load_at(
    input logic [3:0] word,
    input logic [1:0] off,
    input load_op_e   lop,
    input logic [4:0] rd
  );
    present({26'd0, word, off}, '0, '0, rd, 1'b1, 1'b1, 1'b0, st_none, lop);
  endtask

  // Store of random size, offset and data that returns the word index
  task automatic sized_store(input logic [4:0] rs2, output logic [3:0] word);
    logic [31:0] w;
    logic [31:0] o;
    logic [31:0] s;
    logic [31:0] d;
    take_bits(4, w);
    take_bits(2, o);
    take_bits(2, s);
    take_bits(32, d);
    word = w[3:0];
    store_at(word, o[1:0], (s[1:0] == 2'd0) ? st_w : store_op_e'(s[1:0]), d, rs2);
  endtask

  // Any of the five load formats at a random offset
  task automatic formatted_load();
    logic [31:0] w;
    logic [31:0] o;
    logic [31:0] k;
    logic [31:0] r;
    take_bits(4, w);
    take_bits(2, o);
    take_bits(3, k);
    take_bits(5, r);
    load_at(w[3:0], o[1:0], (k >= 1 && k <= 5) ? load_op_e'(k[2:0]) : ld_w, r[4:0]);
  endtask

  task automatic random_alu();
    logic [31:0] v;
    logic [31:0] r;
    logic [31:0] c;
    take_bits(32, v);
    take_bits(5, r);
    take_bits(1, c);
    alu_op(v, r[4:0], c[0]);
  endtask

  // Closing line followed by the verdict
  task automatic report_and_finish(input logic timeout);
    $display("Checks %0d, errors: wb_res %0d, wb_rd %0d, wb_regwrite %0d",
             checks, err_res, err_rd, err_regwrite);
    if (timeout || (err_res + err_rd + err_regwrite) != 0) begin
      $display("Simulation failed");
    end else begin
      $display("Simulation completed successfully");
    end
    $finish;
  endtask

  ////////////////////////////////////////
  // Stimulus phases
  ////////////////////////////////////////

  initial begin
    logic [31:0] d;
    logic [31:0] r;
    logic [31:0] c;
    logic [3:0]  w;
    lfsr_state  = 32'd57;
    stall_phase = 1'b0;
    stall       = 1'b0;
    ex_alures   = '0;
    ex_rs2_data = '0;
    ex_rs2      = '0;
    ex_rd       = '0;
    ex_regwrite = 1'b0;
    ex_memread  = 1'b0;
    ex_memwrite = 1'b0;
    ex_store_op = st_none;
    ex_load_op  = ld_none;
    @(posedge rst_n);
    // Empty stage after reset
    repeat (n_idle) bubble();
    // Fill the window and read it back
    for (int i = 0; i < n_fill; i++) begin
      take_bits(32, d);
      store_at(4'(i), 2'd0, st_w, d, 5'd0);
    end
    for (int i = 0; i < n_fill; i++) begin
      take_bits(5, r);
      load_at(4'(i), 2'd0, ld_w, r[4:0]);
    end
    // Halfword at offset 3 wraps into lane 0
    bubble();
    store_at(4'd5, 2'd3, st_h, 32'h1234_96e1, 5'd0);
    load_at(4'd5, 2'd0, ld_w, 5'd9);
    // Sized stores each read back as a word
    for (int i = 0; i < n_store; i++) begin
      take_bits(5, r);
      sized_store(r[4:0], w);
      take_bits(5, r);
      load_at(w, 2'd0, ld_w, r[4:0]);
    end
    // Load formats mixed with ALU results
    for (int i = 0; i < n_load; i++) begin
      take_bits(1, c);
      if (c[0]) begin
        formatted_load();
      end else begin
        random_alu();
      end
    end
    // Writer of rd followed by a store reading it as rs2 and a word readback
    for (int i = 0; i < n_fwd; i++) begin
      take_bits(5, r);
      take_bits(32, d);
      if (d[0]) begin
        load_at(d[4:1], 2'd0, ld_w, r[4:0]);
      end else begin
        alu_op(d, r[4:0], 1'b1);
      end
      sized_store(r[4:0], w);
      load_at(w, 2'd0, ld_w, 5'd1);
    end
    // Random stall cycles with inputs held
    stall_phase = 1'b1;
    for (int i = 0; i < n_stall; i++) begin
      take_bits(2, c);
      take_bits(5, r);
      if (c[1:0] == 2'd0) begin
        sized_store(r[4:0], w);
      end else if (c[1:0] == 2'd1) begin
        formatted_load();
      end else begin
        random_alu();
      end
    end
    stall_phase = 1'b0;
    repeat (2) bubble();
    repeat (2) @(posedge clk);
    report_and_finish(1'b0);
  end

  // Cycle limit raised by the checker
  initial begin
    wait (timed_out === 1'b1);
    $display("Timeout: run did not end within %0d cycles", timeout_cycles);
    report_and_finish(1'b1);
  end

endmodule : tb_mem_stage

// ==== vlog.f ====
verilog/mem_stage_pkg.sv
verilog/mem_stage_if.sv
verilog/store_lane_unit.sv
verilog/data_ram.sv
verilog/mem_wb_reg.sv
verilog/writeback_select.sv
verilog/mem_stage_top.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/tb_mem_stage.sv
